// ==== common/vr_pkg.sv ====
package vr_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int MSG_W      = 64;
    localparam int VIEW_W     = 16;
    localparam int OP_W       = 16;
    localparam int PAYLOAD_W  = 24;
    localparam int LOG_DEPTH  = 16;
    localparam int LOG_ADDR_W = 4;

    ////////////////////
    // Message types
    ////////////////////
    typedef enum logic [7:0] {
        MSG_SETUP        = 8'd1,
        MSG_PREPARE      = 8'd2,
        MSG_SETUP_ACK    = 8'd3,
        MSG_PREPARE_OK   = 8'd4,
        MSG_PREPARE_NACK = 8'd5,
        MSG_LOG_READ     = 8'd6,
        MSG_LOG_DATA     = 8'd7
    } msg_type_e;

    // One message word with the type in the top byte.
    typedef struct packed {
        msg_type_e              msg_type;
        logic [VIEW_W-1:0]      view;
        logic [OP_W-1:0]        op_num;
        logic [PAYLOAD_W-1:0]   payload;
    } vr_msg_t;

    // Replica state.
    typedef struct packed {
        logic [VIEW_W-1:0]      view;
        logic [OP_W-1:0]        op_num;
    } vr_state_t;

    typedef logic [15:0] conn_id_t; // Connection tag.

endpackage

// ==== common/vr_msg_if.sv ====
`timescale 1ns/10ps

interface vr_msg_if;
    import vr_pkg::*;

    logic       val;
    logic       rdy;
    conn_id_t   info;
    vr_msg_t    data;

    // Transfer on a clock edge with val and rdy both high.
    modport src (
        output val,
        output info,
        output data,
        input  rdy
    );

    modport dst (
        input  val,
        input  info,
        input  data,
        output rdy
    );

endinterface

// ==== prepare/vr_log_mem.sv ====
`timescale 1ns/10ps

module vr_log_mem (
    input  logic                                clk,
    input  logic                                wr_val,
    input  logic [vr_pkg::LOG_ADDR_W-1:0]       wr_addr,
    input  logic [vr_pkg::PAYLOAD_W-1:0]        wr_data,
    input  logic                                rd_val,
    input  logic [vr_pkg::LOG_ADDR_W-1:0]       rd_addr,
    output logic [vr_pkg::PAYLOAD_W-1:0]        rd_data
);
    import vr_pkg::*;

    logic [PAYLOAD_W-1:0] mem [LOG_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_val) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data one cycle after rd_val.
    always_ff @(posedge clk) begin
        if (rd_val) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== prepare/vr_prepare_eng.sv ====
`timescale 1ns/10ps

module vr_prepare_eng (
    input  logic                clk,
    input  logic                reset,
    vr_msg_if.dst               req,
    input  logic                state_wr_val,
    input  vr_pkg::vr_state_t   state_wr_data,
    vr_msg_if.src               reply
);
    import vr_pkg::*;

    vr_state_t              state_rd;
    logic [OP_W-1:0]        op_next;
    logic                   accept;
    logic                   is_read;
    logic                   in_seq;
    logic                   prep_upd;

    logic                   wr_val;
    logic [LOG_ADDR_W-1:0]  wr_addr;
    logic [PAYLOAD_W-1:0]   wr_data;
    logic                   rd_val;
    logic [LOG_ADDR_W-1:0]  rd_addr;
    logic [PAYLOAD_W-1:0]   rd_data;

    logic                   rd_pend;
    conn_id_t               rd_info;
    vr_msg_t                rd_msg;

    logic                   rep_val;
    conn_id_t               rep_info;
    vr_msg_t                rep_data;

    // No accept while a log read waits for its data.
    assign req.rdy  = !rd_pend && (!rep_val || reply.rdy);
    assign accept   = req.val && req.rdy;
    assign is_read  = (req.data.msg_type == MSG_LOG_READ);
    assign op_next  = state_rd.op_num + 16'd1;
    assign in_seq   = (req.data.view == state_rd.view) && (req.data.op_num == op_next);
    assign prep_upd = accept && !is_read && in_seq;

    ////////////////////
    // Replica state
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state_rd <= '0;
        end else if (state_wr_val) begin
            state_rd <= state_wr_data; // Setup wins.
        end else if (prep_upd) begin
            state_rd.op_num <= req.data.op_num;
        end
    end

    ////////////////////
    // Log access
    ////////////////////
    assign wr_val  = prep_upd;
    assign wr_addr = req.data.op_num[LOG_ADDR_W-1:0];
    assign wr_data = req.data.payload;
    assign rd_val  = accept && is_read;
    assign rd_addr = req.data.op_num[LOG_ADDR_W-1:0];

    vr_log_mem log0 (
        .clk     (clk),
        .wr_val  (wr_val),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_val  (rd_val),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ////////////////////
    // Reply slot
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pend <= 1'b0;
            rep_val <= 1'b0;
        end else begin
            rd_pend <= rd_val;
            if (rd_pend || (accept && !is_read)) begin
                rep_val <= 1'b1;
            end else if (reply.rdy) begin
                rep_val <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_val) begin
            rd_info <= req.info;
            rd_msg  <= req.data;
        end
        if (rd_pend) begin
            rep_info          <= rd_info;
            rep_data.msg_type <= MSG_LOG_DATA;
            rep_data.view     <= rd_msg.view;
            rep_data.op_num   <= rd_msg.op_num;
            rep_data.payload  <= rd_data;
        end else if (accept && !is_read) begin
            rep_info          <= req.info;
            rep_data.msg_type <= in_seq ? MSG_PREPARE_OK : MSG_PREPARE_NACK;
            rep_data.view     <= in_seq ? req.data.view : state_rd.view;
            rep_data.op_num   <= in_seq ? req.data.op_num : state_rd.op_num;
            rep_data.payload  <= '0;
        end
    end

    assign reply.val  = rep_val;
    assign reply.info = rep_info;
    assign reply.data = rep_data;

endmodule

// ==== hw/vr_req_splitter.sv ====
`timescale 1ns/10ps

module vr_req_splitter (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_val,
    input  vr_pkg::conn_id_t    in_info,
    input  vr_pkg::vr_msg_t     in_data,
    output logic                in_rdy,
    vr_msg_if.src               setup_out,
    vr_msg_if.src               prep_out
);
    import vr_pkg::*;

    logic       hold_val;
    conn_id_t   hold_info;
    vr_msg_t    hold_data;
    logic       is_setup;
    logic       is_prep;
    logic       hold_done;

    assign is_setup = (hold_data.msg_type == MSG_SETUP);
    assign is_prep  = (hold_data.msg_type == MSG_PREPARE) ||
                      (hold_data.msg_type == MSG_LOG_READ);

    // Unknown types leave the register after one cycle.
    assign hold_done = is_setup ? setup_out.rdy :
                       is_prep  ? prep_out.rdy  : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_val <= 1'b0;
            in_rdy   <= 1'b0;
        end else if (in_val && in_rdy) begin
            hold_val <= 1'b1;
            in_rdy   <= 1'b0;
        end else if (hold_val && hold_done) begin
            hold_val <= 1'b0;
            in_rdy   <= 1'b1; // Slot free again.
        end else if (!hold_val) begin
            in_rdy   <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_val && in_rdy) begin
            hold_info <= in_info;
            hold_data <= in_data;
        end
    end

    assign setup_out.val  = hold_val && is_setup;
    assign setup_out.info = hold_info;
    assign setup_out.data = hold_data;

    assign prep_out.val   = hold_val && is_prep;
    assign prep_out.info  = hold_info;
    assign prep_out.data  = hold_data;

endmodule

// ==== hw/vr_setup_eng.sv ====
`timescale 1ns/10ps

module vr_setup_eng (
    input  logic                clk,
    input  logic                reset,
    vr_msg_if.dst               req,
    output logic                state_wr_val,
    output vr_pkg::vr_state_t   state_wr_data,
    vr_msg_if.src               reply
);
    import vr_pkg::*;

    logic       rep_val;
    conn_id_t   rep_info;
    vr_msg_t    rep_data;
    logic       accept;

    // Slot counts as free while its reply drains.
    assign req.rdy = !rep_val || reply.rdy;
    assign accept  = req.val && req.rdy;

    // State write in the cycle of acceptance.
    assign state_wr_val          = accept;
    assign state_wr_data.view    = req.data.view;
    assign state_wr_data.op_num  = req.data.op_num;

    always_ff @(posedge clk) begin
        if (reset) begin
            rep_val <= 1'b0;
        end else if (accept) begin
            rep_val <= 1'b1;
        end else if (reply.rdy) begin
            rep_val <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rep_info         <= req.info;
            rep_data.msg_type <= MSG_SETUP_ACK;
            rep_data.view    <= req.data.view;
            rep_data.op_num  <= req.data.op_num;
            rep_data.payload <= '0;
        end
    end

    assign reply.val  = rep_val;
    assign reply.info = rep_info;
    assign reply.data = rep_data;

endmodule

// ==== hw/vr_out_merger.sv ====
`timescale 1ns/10ps

module vr_out_merger (
    input  logic                clk,
    input  logic                reset,
    vr_msg_if.dst               in_a,
    vr_msg_if.dst               in_b,
    output logic                out_val,
    output vr_pkg::conn_id_t    out_info,
    output vr_pkg::vr_msg_t     out_data,
    input  logic                out_rdy
);
    import vr_pkg::*;

    logic   rr_ptr; // Low prefers in_a.
    logic   load_ok;
    logic   grant_a;
    logic   grant_b;
    logic   take_a;
    logic   take_b;

    assign load_ok = !out_val || out_rdy;
    assign grant_a = in_a.val && (!in_b.val || !rr_ptr);
    assign grant_b = in_b.val && (!in_a.val || rr_ptr);

    assign in_a.rdy = load_ok && grant_a;
    assign in_b.rdy = load_ok && grant_b;
    assign take_a   = in_a.val && in_a.rdy;
    assign take_b   = in_b.val && in_b.rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_val <= 1'b0;
            rr_ptr  <= 1'b0;
        end else begin
            if (load_ok) begin
                out_val <= take_a || take_b;
            end
            if (take_a || take_b) begin
                rr_ptr <= !rr_ptr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_a) begin
            out_info <= in_a.info;
            out_data <= in_a.data;
        end else if (take_b) begin
            out_info <= in_b.info;
            out_data <= in_b.data;
        end
    end

endmodule

// ==== hw/vr_core.sv ====
`timescale 1ns/10ps

module vr_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_val,
    input  vr_pkg::conn_id_t    in_info,
    input  vr_pkg::vr_msg_t     in_data,
    output logic                in_rdy,
    output logic                out_val,
    output vr_pkg::conn_id_t    out_info,
    output vr_pkg::vr_msg_t     out_data,
    input  logic                out_rdy
);
    import vr_pkg::*;

    vr_msg_if split_setup ();
    vr_msg_if split_prep ();
    vr_msg_if setup_reply ();
    vr_msg_if prep_reply ();

    logic       state_wr_val;
    vr_state_t  state_wr_data;

    ////////////////////
    // Request side
    ////////////////////
    vr_req_splitter split0 (
        .clk       (clk),
        .reset     (reset),
        .in_val    (in_val),
        .in_info   (in_info),
        .in_data   (in_data),
        .in_rdy    (in_rdy),
        .setup_out (split_setup.src),
        .prep_out  (split_prep.src)
    );

    vr_setup_eng setup0 (
        .clk           (clk),
        .reset         (reset),
        .req           (split_setup.dst),
        .state_wr_val  (state_wr_val),
        .state_wr_data (state_wr_data),
        .reply         (setup_reply.src)
    );

    vr_prepare_eng prep0 (
        .clk           (clk),
        .reset         (reset),
        .req           (split_prep.dst),
        .state_wr_val  (state_wr_val),
        .state_wr_data (state_wr_data),
        .reply         (prep_reply.src)
    );

    ////////////////////
    // Reply side
    ////////////////////
    vr_out_merger merge0 (
        .clk      (clk),
        .reset    (reset),
        .in_a     (setup_reply.dst),
        .in_b     (prep_reply.dst),
        .out_val  (out_val),
        .out_info (out_info),
        .out_data (out_data),
        .out_rdy  (out_rdy)
    );

endmodule

// ==== tb/vr_props.sv ====
`timescale 1ns/10ps

module vr_props (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_val,
    input  logic                in_rdy,
    input  logic                out_val,
    input  logic                out_rdy,
    input  vr_pkg::vr_msg_t     out_data
);
    int fail_count = 0; // Failed assertions so far.

    a_reset_idle: assert property (@(posedge clk) reset |=> !out_val)
        else begin
            fail_count = fail_count + 1;
            $error("out_val high right after reset");
        end

    // Output word holds while stalled.
    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_val && !out_rdy |=> out_val && $stable(out_data))
        else begin
            fail_count = fail_count + 1;
            $error("out_val or out_data changed while out_rdy was low");
        end

    a_in_gap: assert property (@(posedge clk) disable iff (reset)
        in_val && in_rdy |=> !in_rdy)
        else begin
            fail_count = fail_count + 1;
            $error("in_rdy high in the cycle after an input transfer");
        end

endmodule

bind vr_core vr_props props0 (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_data (out_data)
);

// ==== tb/vr_checker.sv ====
`timescale 1ns/10ps

module vr_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_val,
    input  logic                in_rdy,
    input  vr_pkg::conn_id_t    in_info,
    input  vr_pkg::vr_msg_t     in_data,
    input  logic                out_val,
    input  logic                out_rdy,
    input  vr_pkg::conn_id_t    out_info,
    input  vr_pkg::vr_msg_t     out_data,
    input  logic                test_end,
    input  int                  test_num,
    output int                  pending,
    output int                  err_count
);
    import vr_pkg::*;

    logic [79:0]            q_setup [$]; // {conn_id, message}.
    logic [79:0]            q_prep [$];
    logic [PAYLOAD_W-1:0]   m_log [LOG_DEPTH];
    vr_state_t              m_state;
    logic                   reset_d = 1'b0;
    int                     n_req = 0;
    int                     n_exp = 0;
    int                     n_got = 0;
    int                     errs = 0;
    int                     err_base = 0;
    int                     got_base = 0;

    assign pending   = q_setup.size() + q_prep.size();
    assign err_count = errs;

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset and first prepare";
            2:       return "setup";
            3:       return "prepare sequence";
            4:       return "log read";
            5:       return "random back-pressure";
            default: return "reply totals";
        endcase
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        if (got !== exp) begin
            errs++;
            $display("CHECK FAILED t=%0t %s expected 0x%h got 0x%h", $time, name, exp, got);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    task automatic model_request();
        vr_msg_t m;
        vr_msg_t r;
        m = in_data;
        r = '0;
        r.view = m.view;
        r.op_num = m.op_num;
        n_req++;
        if (m.msg_type == MSG_SETUP) begin
            m_state.view = m.view;
            m_state.op_num = m.op_num;
            r.msg_type = MSG_SETUP_ACK;
            q_setup.push_back({in_info, r});
            n_exp++;
        end else if (m.msg_type == MSG_PREPARE) begin
            if (m.view == m_state.view && m.op_num == m_state.op_num + 16'd1) begin
                m_log[m.op_num[LOG_ADDR_W-1:0]] = m.payload;
                m_state.op_num = m.op_num;
                r.msg_type = MSG_PREPARE_OK;
            end else begin
                r.msg_type = MSG_PREPARE_NACK; // Reports the state as it stands.
                r.view = m_state.view;
                r.op_num = m_state.op_num;
            end
            q_prep.push_back({in_info, r});
            n_exp++;
        end else if (m.msg_type == MSG_LOG_READ) begin
            r.msg_type = MSG_LOG_DATA;
            r.payload = m_log[m.op_num[LOG_ADDR_W-1:0]];
            q_prep.push_back({in_info, r});
            n_exp++;
        end
    endtask

    task automatic compare_reply();
        logic [79:0] exp;
        n_got++;
        if (out_data.msg_type == MSG_SETUP_ACK && q_setup.size() != 0) begin
            exp = q_setup.pop_front();
        end else if (out_data.msg_type != MSG_SETUP_ACK && q_prep.size() != 0) begin
            exp = q_prep.pop_front();
        end else begin
            errs++;
            $display("t=%0t: reply of type %0d for conn_id %0d has no request waiting",
                     $time, out_data.msg_type, out_info);
            return;
        end
        check_field("out_info", 64'(exp[79:64]), 64'(out_info));
        check_field("out_data", exp[63:0], out_data);
    endtask

    task automatic close_test();
        if (test_num == 6 && pending != 0) begin
            errs++;
            $display("%0d replies were still missing at the end of the run", pending);
        end
        if (test_num == 6 && n_got != n_exp) begin
            errs++;
            $display("%0d replies arrived where the model expects %0d", n_got, n_exp);
        end
        if (errs == err_base) begin
            $display("test %0d %s: ok, %0d replies", test_num, test_name(test_num),
                     n_got - got_base);
        end else begin
            $display("test %0d %s: FAILED, %0d errors", test_num, test_name(test_num),
                     errs - err_base);
        end
        err_base = errs;
        got_base = n_got;
        if (test_num == 6) begin
            $display("totals: %0d requests, %0d replies expected, %0d received, %0d errors",
                     n_req, n_exp, n_got, errs);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            m_state = '0;
            q_setup.delete();
            q_prep.delete();
        end else begin
            if (reset_d) begin
                check_field("out_val", 64'(1'b0), 64'(out_val)); // First cycle out of reset.
            end
            if (in_val && in_rdy) begin
                model_request();
            end
            if (out_val && out_rdy) begin
                compare_reply();
            end
            if (test_end) begin
                close_test();
            end
        end
        reset_d = reset;
    end

endmodule

// ==== tb/vr_tb.sv ====
`timescale 1ns/10ps

module vr_tb;
    import vr_pkg::*;

    logic                   clk;
    logic                   reset;
    logic                   in_val;
    conn_id_t               in_info;
    vr_msg_t                in_data;
    logic                   in_rdy;
    logic                   out_val;
    conn_id_t               out_info;
    vr_msg_t                out_data;
    logic                   out_rdy;

    logic                   test_end;
    int                     test_num;
    int                     pending;
    int                     err_count;

    integer                 seed = 46;
    integer                 bp_seed = 47; // Back-pressure stream.
    logic                   timed_out;
    logic [15:0]            conn_ctr;
    logic [15:0]            sh_view;
    logic [15:0]            sh_op;
    logic [LOG_DEPTH-1:0]   written;

    vr_core dut0 (
        .clk      (clk),
        .reset    (reset),
        .in_val   (in_val),
        .in_info  (in_info),
        .in_data  (in_data),
        .in_rdy   (in_rdy),
        .out_val  (out_val),
        .out_info (out_info),
        .out_data (out_data),
        .out_rdy  (out_rdy)
    );

    vr_checker chk0 (
        .clk      (clk),
        .reset    (reset),
        .in_val   (in_val),
        .in_rdy   (in_rdy),
        .in_info  (in_info),
        .in_data  (in_data),
        .out_val  (out_val),
        .out_rdy  (out_rdy),
        .out_info (out_info),
        .out_data (out_data),
        .test_end (test_end),
        .test_num (test_num),
        .pending  (pending),
        .err_count(err_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Output stall on about 30 percent of cycles.
    initial begin
        out_rdy = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_rdy = ({$random(bp_seed)} % 100) >= 30;
        end
    end

    task automatic send(input logic [7:0] t, input logic [15:0] v,
                        input logic [15:0] op, input logic [23:0] pl);
        int n;
        if (timed_out) return;
        in_val   = 1'b1;
        in_info  = conn_ctr;
        in_data  = {t, v, op, pl};
        conn_ctr = conn_ctr + 16'd1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!in_rdy && n < 200);
        if (!in_rdy) begin
            timed_out = 1'b1;
            $display("timeout: request with conn_id %0d was never accepted", in_info);
        end
        #1;
        in_val = 1'b0;
    endtask

    // Shadow state keeps most prepares in sequence.
    task automatic issue(input logic [7:0] t, input logic [15:0] v,
                         input logic [15:0] op, input logic [23:0] pl);
        if (t == MSG_SETUP) begin
            sh_view = v;
            sh_op = op;
        end else if (t == MSG_PREPARE && v == sh_view && op == sh_op + 16'd1) begin
            sh_op = op;
            written[op[LOG_ADDR_W-1:0]] = 1'b1;
        end
        send(t, v, op, pl);
    endtask

    task automatic random_request();
        int             pick;
        logic [3:0]     ent;
        logic [23:0]    pl;
        pick = {$random(seed)} % 100;
        pl = 24'($random(seed));
        if (pick < 5) begin
            issue(8'd8 + 8'({$random(seed)} % 200), sh_view, sh_op, pl); // Unknown type.
        end else if (pick < 12) begin
            issue(MSG_SETUP, sh_view + 16'({$random(seed)} % 3),
                  16'({$random(seed)} % 64), 24'h0);
        end else if (pick < 30 && written != '0) begin
            ent = 4'($random(seed));
            while (!written[ent]) begin
                ent = ent + 4'd1;
            end
            issue(MSG_LOG_READ, 16'($random(seed)), {12'($random(seed)), ent}, 24'h0);
        end else if (pick < 35) begin
            issue(MSG_PREPARE, sh_view + 16'd1, sh_op + 16'd1, pl);
        end else if (pick < 40) begin
            issue(MSG_PREPARE, sh_view, sh_op + 16'd2 + 16'({$random(seed)} % 5), pl);
        end else begin
            issue(MSG_PREPARE, sh_view, sh_op + 16'd1, pl);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (pending != 0 && n < 5000);
        if (pending != 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d replies never arrived", pending);
        end
    endtask

    task automatic close_test(input int n);
        test_num = n;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        in_val    = 1'b0;
        in_info   = '0;
        in_data   = '0;
        test_end  = 1'b0;
        test_num  = 0;
        timed_out = 1'b0;
        conn_ctr  = 16'd1;
        sh_view   = 16'd0;
        sh_op     = 16'd0;
        written   = '0;
        reset     = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        issue(MSG_PREPARE, 16'd0, 16'd1, 24'h111111);
        wait_idle();
        close_test(1);

        issue(MSG_SETUP, 16'd3, 16'd20, 24'h0);
        issue(MSG_PREPARE, 16'd3, 16'd21, 24'h215021);
        issue(MSG_PREPARE, 16'd3, 16'd22, 24'h225022);
        wait_idle();
        close_test(2);

        issue(MSG_PREPARE, 16'd3, 16'd23, 24'h235023);
        issue(MSG_PREPARE, 16'd2, 16'd24, 24'hbad024); // Stale view.
        issue(MSG_PREPARE, 16'd3, 16'd30, 24'hbad030); // Gap in op_num.
        issue(MSG_PREPARE, 16'd3, 16'd23, 24'hbad023);
        issue(MSG_PREPARE, 16'd3, 16'd24, 24'h245024);
        wait_idle();
        close_test(3);

        issue(MSG_LOG_READ, 16'd3, 16'd21, 24'h0);
        issue(MSG_LOG_READ, 16'd3, 16'd24, 24'h0);
        issue(MSG_LOG_READ, 16'd0, 16'd1, 24'h0);
        issue(MSG_SETUP, 16'd3, 16'd36, 24'h0);
        issue(MSG_PREPARE, 16'd3, 16'd37, 24'h375037); // Overwrites entry 5.
        issue(MSG_LOG_READ, 16'd3, 16'd21, 24'h0);
        wait_idle();
        close_test(4);

        for (int i = 0; i < 2000; i++) begin
            if (timed_out) break;
            random_request();
        end
        wait_idle();
        close_test(5);
        close_test(6);

        if (!timed_out && err_count == 0 && dut0.props0.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/vr_pkg.sv
common/vr_msg_if.sv
prepare/vr_log_mem.sv
prepare/vr_prepare_eng.sv
hw/vr_req_splitter.sv
hw/vr_setup_eng.sv
hw/vr_out_merger.sv
hw/vr_core.sv
tb/vr_props.sv
tb/vr_checker.sv
tb/vr_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the simulation with Verilator; the log decides pass or fail.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module vr_tb -f flist.f -o vr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vr_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
